// ==== project.f ====
design/cache_pkg.sv
design/cache_ifs.sv
design/front_end.sv
design/cache_memory.sv
design/write_buffer.sv
design/back_end_native.sv
design/cache_control.sv
design/cache_top.sv
verification/clk_gen.sv
verification/mem_model.sv
verification/tb_cache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_cache -f project.f

# The log decides pass or fail
status=0
./obj_dir/Vtb_cache > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Done: no errors" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed (exit status ${status})"
exit 1

// ==== verification/tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache
   import cache_pkg::*;
();

   logic              clk;
   logic              rst_n;
   logic              req;
   logic [ADDR_W:0]   addr;
   logic [DATA_W-1:0] wdata;
   logic [NBYTES-1:0] wstrb;
   logic [DATA_W-1:0] rdata;
   logic              ack;
   logic              mem_req;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata;
   logic [NBYTES-1:0] mem_wstrb;
   logic [DATA_W-1:0] mem_rdata;
   logic              mem_ack;
   logic              stall;
   logic              started;              // First request issued

   logic [DATA_W-1:0]          shadow [1<<ADDR_W];  // Last strobed bytes per word
   logic [(1<<LINE_OFF_W)-1:0] line_valid;          // Expected cache state
   logic [TAG_W-1:0]           line_tag [1<<LINE_OFF_W];
   int                         n_read_hit;
   int                         n_read_miss;
   int                         n_write_hit;
   int                         n_write_miss;
   wt_entry_t                  exp_writes [$];      // Writes still to reach memory
   wt_entry_t                  head;
   int                         cycles;

   clk_gen clk0 (.clk);

   cache_top dut0
   (
      .clk, .rst_n,
      .req, .addr, .wdata, .wstrb, .rdata, .ack,
      .mem_req, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata, .mem_ack
   );

   mem_model mem0
   (
      .clk, .rst_n, .stall,
      .mem_req, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata, .mem_ack
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "run stopped at the first failing check");
   endtask

   function automatic logic [DATA_W-1:0] fill_pattern(input logic [ADDR_W-1:0] a);
      return {4'h5, ~a, a};                 // Every address bit shows up
   endfunction

   ////////////////////
   // Bus access
   ////////////////////
   task automatic bus_access(input logic [ADDR_W:0] a, input logic [DATA_W-1:0] d,
                             input logic [NBYTES-1:0] s, output logic [DATA_W-1:0] rd);
      req     = 1'b1;
      addr    = a;
      wdata   = d;
      wstrb   = s;
      started = 1'b1;
      do
         @(negedge clk);
      while (!ack);
      rd  = rdata;
      req = 1'b0;                           // Next call may raise it again at once
   endtask

   task automatic read_word(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0]     got;
      logic [LINE_OFF_W-1:0] idx;
      logic [TAG_W-1:0]      tg;
      idx = a[WORD_OFF_W +: LINE_OFF_W];
      tg  = a[ADDR_W-1 -: TAG_W];
      if (line_valid[idx] && (line_tag[idx] == tg))
         n_read_hit++;
      else
      begin
         n_read_miss++;
         line_valid[idx] = 1'b1;            // Read miss allocates
         line_tag[idx]   = tg;
      end
      bus_access({1'b0, a}, '0, '0, got);
      assert (got == shadow[a])
         else report_failure($sformatf("mismatch at %0t: read %h returned %h, expected %h",
                                       $time, a, got, shadow[a]));
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [NBYTES-1:0] s);
      logic [DATA_W-1:0]     ignored;
      logic [LINE_OFF_W-1:0] idx;
      wt_entry_t             e;
      idx = a[WORD_OFF_W +: LINE_OFF_W];
      if (line_valid[idx] && (line_tag[idx] == a[ADDR_W-1 -: TAG_W]))
         n_write_hit++;
      else
         n_write_miss++;                    // No allocation on a write
      e.addr = a;
      e.data = d;
      e.strb = s;
      exp_writes.push_back(e);
      for (int b = 0; b < NBYTES; b++)
      begin
         if (s[b])
            shadow[a][8*b +: 8] = d[8*b +: 8];
      end
      bus_access({1'b0, a}, d, s, ignored);
   endtask

   ////////////////////
   // Control space
   ////////////////////
   task automatic read_reg(input ctrl_reg_e r, output logic [DATA_W-1:0] v);
      bus_access({1'b1, {(ADDR_W-CTRL_ADDR_W){1'b0}}, r}, '0, '0, v);
   endtask

   task automatic send_cmd(input ctrl_reg_e r);
      logic [DATA_W-1:0] ignored;
      bus_access({1'b1, {(ADDR_W-CTRL_ADDR_W){1'b0}}, r}, '0, {NBYTES{1'b1}}, ignored);
      if (r == CTRL_INVALIDATE)
         line_valid = '0;
      else if (r == CTRL_CLEAR)
      begin
         n_read_hit   = 0;
         n_read_miss  = 0;
         n_write_hit  = 0;
         n_write_miss = 0;
      end
   endtask

   task automatic check_count(input ctrl_reg_e r, input int expected);
      logic [DATA_W-1:0] v;
      read_reg(r, v);
      assert (v == DATA_W'(expected))
         else report_failure($sformatf("mismatch at %0t: %s reads %0d, expected %0d",
                                       $time, r.name(), v, expected));
   endtask

   task automatic verify_counters();
      check_count(CTRL_READ_HIT, n_read_hit);
      check_count(CTRL_READ_MISS, n_read_miss);
      check_count(CTRL_WRITE_HIT, n_write_hit);
      check_count(CTRL_WRITE_MISS, n_write_miss);
   endtask

   // Buffer empty, then the last memory write finished
   task automatic wait_drained();
      logic [DATA_W-1:0] v;
      v = '0;
      while (v != 32'd1)
         read_reg(CTRL_WTBUF_EMPTY, v);
      while (mem_req)
         @(negedge clk);
   endtask

   task automatic audit_memory();
      for (int i = 0; i < (1 << ADDR_W); i++)
      begin
         assert (mem0.mem[ADDR_W'(i)] == shadow[ADDR_W'(i)])
            else report_failure($sformatf("mismatch at %0t: memory %h holds %h, expected %h",
                                          $time, ADDR_W'(i), mem0.mem[ADDR_W'(i)],
                                          shadow[ADDR_W'(i)]));
      end
   endtask

   ////////////////////
   // Monitors
   ////////////////////
   a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
      !started |-> !ack && !mem_req)
      else report_failure("ack or mem_req went high before the first request");

   // Memory writes in issue order
   always @(posedge clk)
   begin
      if (rst_n && mem_req && mem_ack && (mem_wstrb != '0))
      begin
         assert (exp_writes.size() != 0)
            else report_failure("memory write seen with no write outstanding");
         if (exp_writes.size() != 0)
         begin
            head = exp_writes.pop_front();
            assert ((mem_addr == head.addr) && (mem_wdata == head.data)
                    && (mem_wstrb == head.strb))
               else report_failure($sformatf("mismatch at %0t: memory write %h/%h/%h, expected %h/%h/%h",
                                             $time, mem_addr, mem_wdata, mem_wstrb,
                                             head.addr, head.data, head.strb));
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      assert (cycles < 20000)               // Worst case ~300 accesses with slow fills
         else report_failure("timeout, the tests did not finish within 20000 cycles");
   end

   ////////////////////
   // Stimulus
   ////////////////////
   initial
   begin
      logic [DATA_W-1:0] v;
      logic [ADDR_W-1:0] a;
      void'($urandom(32'hcfce_5e19));
      rst_n      = 1'b0;
      req        = 1'b0;
      addr       = '0;
      wdata      = '0;
      wstrb      = '0;
      stall      = 1'b0;
      started    = 1'b0;
      cycles     = 0;
      line_valid = '0;
      n_read_hit   = 0;
      n_read_miss  = 0;
      n_write_hit  = 0;
      n_write_miss = 0;
      for (int i = 0; i < (1 << ADDR_W); i++)
      begin
         shadow[ADDR_W'(i)]   = fill_pattern(ADDR_W'(i));
         mem0.mem[ADDR_W'(i)] = fill_pattern(ADDR_W'(i));
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (4) @(negedge clk);            // Idle, outputs must stay low

      // Hits, misses, partial write, conflict on line 4
      send_cmd(CTRL_CLEAR);
      read_word(14'h010);
      read_word(14'h010);
      read_word(14'h013);
      write_word(14'h012, 32'ha5a5_5a5a, 4'b0101);
      read_word(14'h012);
      write_word(14'h050, 32'h1234_5678, 4'hf);   // Other tag, same line
      read_word(14'h050);
      read_word(14'h012);                         // Evicted, comes from memory
      verify_counters();

      // Line 4 holds tag 0 here, only the invalidate makes it miss
      send_cmd(CTRL_INVALIDATE);
      read_word(14'h013);
      read_word(14'h013);
      verify_counters();

      // Random mix over four tags
      for (int n = 0; n < 240; n++)
      begin
         a = ADDR_W'($urandom_range(255, 0));
         if ($urandom_range(9, 0) < 4)
            write_word(a, $urandom(), NBYTES'($urandom_range(15, 1)));
         else
            read_word(a);
         if (n % 80 == 79)
            send_cmd(CTRL_INVALIDATE);
      end
      verify_counters();
      wait_drained();
      audit_memory();

      // Back-pressure, memory held so the buffer fills
      stall <= 1'b1;
      for (int k = 0; k < 5; k++)
         write_word(ADDR_W'(256 + k), $urandom(), 4'hf);
      read_reg(CTRL_WTBUF_FULL, v);
      assert (v == 32'd1)
         else report_failure($sformatf("mismatch at %0t: full flag reads %0d after five writes",
                                       $time, v));
      fork
         write_word(14'h105, $urandom(), 4'hc);
         begin
            repeat (6)
            begin
               @(negedge clk);
               assert (!ack)
                  else report_failure("write acked while the buffer was full");
            end
            stall <= 1'b0;
         end
      join
      wait_drained();
      audit_memory();
      verify_counters();
      assert (exp_writes.size() == 0)
         else report_failure("writes never reached memory");

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// Word memory behind the native req/ack port
module mem_model
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              stall,      // Holds every ack back while high
   input  logic              mem_req,
   input  logic [ADDR_W-1:0] mem_addr,
   input  logic [DATA_W-1:0] mem_wdata,
   input  logic [NBYTES-1:0] mem_wstrb,
   output logic [DATA_W-1:0] mem_rdata,
   output logic              mem_ack
);

   logic [DATA_W-1:0] mem [1<<ADDR_W];   // Filled by the testbench at time 0
   int                delay;              // Cycles left before the ack
   logic              armed;              // Delay drawn for this request

   initial
   begin
      mem_ack   = 1'b0;
      mem_rdata = '0;
      armed     = 1'b0;
   end

   // Answers on the falling edge, 0 to 3 cycles late
   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         mem_ack <= 1'b0;
         armed = 1'b0;
      end
      else if (mem_ack)
      begin
         mem_ack <= 1'b0;                   // One cycle per transfer
         armed = 1'b0;
      end
      else if (mem_req && !stall)
      begin
         if (!armed)
         begin
            delay = $urandom_range(3, 0);
            armed = 1'b1;
         end
         if (delay == 0)
         begin
            mem_ack <= 1'b1;
            if (mem_wstrb == '0)            // Read
               mem_rdata <= mem[mem_addr];
            else
            begin
               for (int b = 0; b < NBYTES; b++)
               begin
                  if (mem_wstrb[b])
                     mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
               end
            end
         end
         else
            delay--;
      end
   end

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock
module clk_gen
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;   // 8 ns period
   end

endmodule

`default_nettype wire

// ==== design/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   // Front-end port
   input  logic              req,
   input  logic [ADDR_W:0]   addr,
   input  logic [DATA_W-1:0] wdata,
   input  logic [NBYTES-1:0] wstrb,
   output logic [DATA_W-1:0] rdata,
   output logic              ack,
   // Memory port
   output logic              mem_req,
   output logic [ADDR_W-1:0] mem_addr,
   output logic [DATA_W-1:0] mem_wdata,
   output logic [NBYTES-1:0] mem_wstrb,
   input  logic [DATA_W-1:0] mem_rdata,
   input  logic              mem_ack
);

   logic                   data_req;
   logic                   data_ack;
   logic [ADDR_W-1:0]      data_addr;
   logic [DATA_W-1:0]      data_wdata;
   logic [DATA_W-1:0]      data_rdata;
   logic [NBYTES-1:0]      data_wstrb;
   logic                   ctrl_req;
   logic                   ctrl_ack;
   logic                   ctrl_wr;
   logic [CTRL_ADDR_W-1:0] ctrl_addr;
   logic [DATA_W-1:0]      ctrl_rdata;
   logic                   read_hit;
   logic                   read_miss;
   logic                   write_hit;
   logic                   write_miss;
   logic                   wtbuf_empty;
   logic                   wtbuf_full;
   logic                   invalidate;

   wr_chan_if   wr_push ();  // Cache to buffer
   wr_chan_if   wr_pop ();   // Buffer to memory side
   fill_chan_if fill ();

   front_end u_front_end
   (
      .clk, .rst_n,
      .req, .wdata, .wstrb, .addr, .rdata, .ack,
      .data_req, .data_addr, .data_wdata, .data_wstrb, .data_rdata, .data_ack,
      .ctrl_req, .ctrl_addr, .ctrl_wr, .ctrl_rdata, .ctrl_ack
   );

   cache_memory u_cache_memory
   (
      .clk, .rst_n,
      .req   (data_req),
      .addr  (data_addr),
      .wdata (data_wdata),
      .wstrb (data_wstrb),
      .rdata (data_rdata),
      .ack   (data_ack),
      .wr_push, .fill,
      .wtbuf_empty, .invalidate,
      .read_hit, .read_miss, .write_hit, .write_miss
   );

   write_buffer u_write_buffer
   (
      .clk, .rst_n,
      .wr_push, .wr_pop,
      .empty (wtbuf_empty),
      .full  (wtbuf_full)
   );

   back_end_native u_back_end
   (
      .clk, .rst_n,
      .wr_pop, .fill,
      .mem_req, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata, .mem_ack
   );

   cache_control u_cache_control
   (
      .clk, .rst_n,
      .req   (ctrl_req),
      .addr  (ctrl_addr),
      .wr    (ctrl_wr),
      .rdata (ctrl_rdata),
      .ack   (ctrl_ack),
      .read_hit, .read_miss, .write_hit, .write_miss,
      .wtbuf_empty, .wtbuf_full, .invalidate
   );

endmodule

`default_nettype wire

// ==== design/cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_control
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   req,
   input  logic [CTRL_ADDR_W-1:0] addr,
   input  logic                   wr,
   output logic [DATA_W-1:0]      rdata,
   output logic                   ack,
   input  logic                   read_hit,
   input  logic                   read_miss,
   input  logic                   write_hit,
   input  logic                   write_miss,
   input  logic                   wtbuf_empty,
   input  logic                   wtbuf_full,
   output logic                   invalidate
);

   logic [3:0]       events;   // Same order as registers 0 to 3
   logic             clear;
   logic [CNT_W-1:0] cnt [4];

   assign events = {write_miss, write_hit, read_miss, read_hit};

   // Answers in the cycle the request is presented
   assign ack        = req;
   assign invalidate = req && wr && (ctrl_reg_e'(addr) == CTRL_INVALIDATE);
   assign clear      = req && wr && (ctrl_reg_e'(addr) == CTRL_CLEAR);

   ////////////////////
   // Counters
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (!rst_n || clear)
      begin
         for (int i = 0; i < 4; i++)
            cnt[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < 4; i++)
         begin
            if (events[i] && (cnt[i] != '1))     // Saturate
               cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   // Register readback
   always_comb
   begin
      case (ctrl_reg_e'(addr))
         CTRL_READ_HIT, CTRL_READ_MISS, CTRL_WRITE_HIT, CTRL_WRITE_MISS:
            rdata = DATA_W'(cnt[addr[1:0]]);
         CTRL_WTBUF_EMPTY:
            rdata = DATA_W'(wtbuf_empty);
         CTRL_WTBUF_FULL:
            rdata = DATA_W'(wtbuf_full);
         default:
            rdata = '0;                          // Command registers read zero
      endcase
   end

endmodule

`default_nettype wire

// ==== design/back_end_native.sv ====
`timescale 1ns/1ps
`default_nettype none

module back_end_native
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   wr_chan_if.sink           wr_pop,
   fill_chan_if.backend      fill,
   output logic              mem_req,
   output logic [ADDR_W-1:0] mem_addr,
   output logic [DATA_W-1:0] mem_wdata,
   output logic [NBYTES-1:0] mem_wstrb,     // Zero for a read
   input  logic [DATA_W-1:0] mem_rdata,
   input  logic              mem_ack
);

   typedef enum logic [1:0] {B_IDLE, B_WRITE, B_FILL} be_state_t;

   be_state_t             state;
   logic [WORD_OFF_W-1:0] word_cnt;

   // Fill wins, the buffer is already empty by then
   assign wr_pop.ready = (state == B_IDLE) && !fill.req;

   assign fill.word_valid = (state == B_FILL) && mem_ack;
   assign fill.word_idx   = word_cnt;
   assign fill.rdata      = mem_rdata;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= B_IDLE;
         mem_req  <= 1'b0;
         word_cnt <= '0;
      end
      else
      begin
         case (state)
            B_IDLE:
               if (fill.req)
               begin
                  state    <= B_FILL;
                  mem_req  <= 1'b1;
                  word_cnt <= '0;
               end
               else if (wr_pop.valid)
               begin
                  state   <= B_WRITE;
                  mem_req <= 1'b1;
               end
            B_WRITE:
               if (mem_ack)
               begin
                  state   <= B_IDLE;
                  mem_req <= 1'b0;
               end
            default:
               if (mem_ack)
               begin
                  if (word_cnt == '1)       // Last word of the line
                  begin
                     state   <= B_IDLE;
                     mem_req <= 1'b0;
                  end
                  word_cnt <= word_cnt + 1'b1;
               end
         endcase
      end
   end

   // Request fields
   always_ff @(posedge clk)
   begin
      if (state == B_IDLE && fill.req)
      begin
         mem_addr  <= {fill.addr, {WORD_OFF_W{1'b0}}};
         mem_wstrb <= '0;
      end
      else if (wr_pop.valid && wr_pop.ready)
      begin
         mem_addr  <= wr_pop.entry.addr;
         mem_wdata <= wr_pop.entry.data;
         mem_wstrb <= wr_pop.entry.strb;
      end
      else if (state == B_FILL && mem_ack)
         mem_addr <= {fill.addr, word_cnt + 1'b1};    // Next word
   end

   a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req && !mem_ack |=> mem_req && $stable(mem_addr)
         && $stable(mem_wdata) && $stable(mem_wstrb))
      else $error("back_end_native: memory request changed before mem_ack");

endmodule

`default_nettype wire

// ==== design/write_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_buffer
   import cache_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   wr_chan_if.sink   wr_push,
   wr_chan_if.source wr_pop,
   output logic    empty,
   output logic    full
);

   logic [WTBUF_DEPTH_W:0]   wptr;   // Extra bit tells full from empty
   logic [WTBUF_DEPTH_W:0]   rptr;
   logic                     push;
   logic                     pop;
   wt_entry_t                fifo_mem [1<<WTBUF_DEPTH_W];

   assign empty = (wptr == rptr);
   assign full  = (wptr[WTBUF_DEPTH_W] != rptr[WTBUF_DEPTH_W])
               && (wptr[WTBUF_DEPTH_W-1:0] == rptr[WTBUF_DEPTH_W-1:0]);

   assign wr_push.ready = !full;
   assign push          = wr_push.valid && wr_push.ready;

   assign wr_pop.valid  = !empty;
   assign wr_pop.entry  = fifo_mem[rptr[WTBUF_DEPTH_W-1:0]];  // Oldest entry
   assign pop           = wr_pop.valid && wr_pop.ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wptr <= '0;
         rptr <= '0;
      end
      else
      begin
         if (push)
            wptr <= wptr + 1'b1;
         if (pop)
            rptr <= rptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         fifo_mem[wptr[WTBUF_DEPTH_W-1:0]] <= wr_push.entry;
   end

   // A refused write must wait unchanged
   a_push_held: assert property (@(posedge clk) disable iff (!rst_n)
      wr_push.valid && !wr_push.ready |=> wr_push.valid && $stable(wr_push.entry))
      else $error("write_buffer: pending write dropped or changed");

endmodule

`default_nettype wire

// ==== design/cache_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_memory
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] wdata,
   input  logic [NBYTES-1:0] wstrb,
   output logic [DATA_W-1:0] rdata,
   output logic              ack,
   wr_chan_if.source         wr_push,
   fill_chan_if.cache        fill,
   input  logic              wtbuf_empty,
   input  logic              invalidate,
   output logic              read_hit,
   output logic              read_miss,
   output logic              write_hit,
   output logic              write_miss
);

   typedef enum logic [1:0] {S_IDLE, S_WAIT, S_FILL, S_DONE} state_t;

   state_t                  state;
   logic [TAG_W-1:0]        tag;
   logic [LINE_OFF_W-1:0]   index;
   logic [WORD_OFF_W-1:0]   word;
   logic                    hit;
   logic                    is_write;
   logic                    push_done;
   logic                    fill_last;
   logic [(1<<LINE_OFF_W)-1:0] valid;
   logic [TAG_W-1:0]        tag_mem  [1<<LINE_OFF_W];
   logic [DATA_W-1:0]       data_mem [1<<(LINE_OFF_W+WORD_OFF_W)];

   ////////////////////
   // Lookup
   ////////////////////
   assign tag   = addr[ADDR_W-1 -: TAG_W];
   assign index = addr[WORD_OFF_W +: LINE_OFF_W];
   assign word  = addr[WORD_OFF_W-1:0];

   assign hit      = valid[index] && (tag_mem[index] == tag);
   assign is_write = |wstrb;
   assign rdata    = data_mem[{index, word}];     // Async array read

   // Every write goes to the buffer, hit or not
   assign wr_push.valid      = req && is_write && (state == S_IDLE);
   assign wr_push.entry.addr = addr;
   assign wr_push.entry.data = wdata;
   assign wr_push.entry.strb = wstrb;
   assign push_done          = wr_push.valid && wr_push.ready;

   // Event pulses, one per request
   assign read_hit   = (state == S_IDLE) && req && !is_write && hit;
   assign read_miss  = (state == S_IDLE) && req && !is_write && !hit;
   assign write_hit  = push_done && hit;
   assign write_miss = push_done && !hit;

   assign ack = read_hit || push_done || (state == S_DONE);

   ////////////////////
   // Miss handling
   ////////////////////
   assign fill.req  = (state == S_FILL);
   assign fill.addr = {tag, index};
   assign fill_last = fill.word_valid && (fill.word_idx == '1);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= S_IDLE;
      else
      begin
         case (state)
            S_IDLE:
               if (read_miss)
                  state <= S_WAIT;
            S_WAIT:                         // Older writes reach memory first
               if (wtbuf_empty)
                  state <= S_FILL;
            S_FILL:
               if (fill_last)
                  state <= S_DONE;
            default:                        // S_DONE answers from the new line
               state <= S_IDLE;
         endcase
      end
   end

   // Valid bits
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid <= '0;
      else if (invalidate)
         valid <= '0;
      else if (fill_last)
         valid[index] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (fill_last)
         tag_mem[index] <= tag;
   end

   // Fill words, else byte merge on a write hit
   always_ff @(posedge clk)
   begin
      if (fill.req && fill.word_valid)
         data_mem[{index, fill.word_idx}] <= fill.rdata;
      else if (write_hit)
      begin
         for (int b = 0; b < NBYTES; b++)
         begin
            if (wstrb[b])
               data_mem[{index, word}][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   ////////////////////
   // Checks
   ////////////////////
   // Missed line stays invalid until its last word
   a_no_hit_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
      fill.req |-> !hit)
      else $error("cache_memory: hit while a fill is pending");

   a_fill_then_ack: assert property (@(posedge clk) disable iff (!rst_n)
      fill_last |=> ack && hit)
      else $error("cache_memory: filled line not answered");

endmodule

`default_nettype wire

// ==== design/front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module front_end
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Requester side
   input  logic                   req,
   input  logic [DATA_W-1:0]      wdata,
   input  logic [NBYTES-1:0]      wstrb,
   input  logic [ADDR_W:0]        addr,       // Top bit selects control space
   output logic [DATA_W-1:0]      rdata,
   output logic                   ack,
   // Cache data path
   output logic                   data_req,
   output logic [ADDR_W-1:0]      data_addr,
   output logic [DATA_W-1:0]      data_wdata,
   output logic [NBYTES-1:0]      data_wstrb,
   input  logic [DATA_W-1:0]      data_rdata,
   input  logic                   data_ack,
   // Control block
   output logic                   ctrl_req,
   output logic [CTRL_ADDR_W-1:0] ctrl_addr,
   output logic                   ctrl_wr,
   input  logic [DATA_W-1:0]      ctrl_rdata,
   input  logic                   ctrl_ack
);

   logic              pending;   // A registered request awaits its ack
   logic [ADDR_W:0]   addr_reg;
   logic [DATA_W-1:0] wdata_reg;
   logic [NBYTES-1:0] wstrb_reg;

   // Load when free or when the current request is answered
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pending <= 1'b0;
      else if (!pending || ack)
         pending <= req;
   end

   always_ff @(posedge clk)
   begin
      if (!pending || ack)
      begin
         addr_reg  <= addr;
         wdata_reg <= wdata;
         wstrb_reg <= wstrb;
      end
   end

   // Steering by the top address bit
   assign data_req   = pending && !addr_reg[ADDR_W];
   assign data_addr  = addr_reg[ADDR_W-1:0];
   assign data_wdata = wdata_reg;
   assign data_wstrb = wstrb_reg;

   assign ctrl_req  = pending && addr_reg[ADDR_W];
   assign ctrl_addr = addr_reg[CTRL_ADDR_W-1:0];
   assign ctrl_wr   = |wstrb_reg;          // Any strobe makes a command write

   // Merged answer
   assign ack   = data_ack || ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : data_rdata;

   a_one_answer: assert property (@(posedge clk) disable iff (!rst_n)
      !(data_ack && ctrl_ack))
      else $error("front_end: cache and control answered together");

endmodule

`default_nettype wire

// ==== design/cache_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Valid/ready channel carrying one write-through entry
interface wr_chan_if
   import cache_pkg::*;
   ();

   logic      valid;
   wt_entry_t entry;
   logic      ready;

   modport source (output valid, output entry, input ready);
   modport sink   (input valid, input entry, output ready);

endinterface

// Line fill between the cache arrays and the memory side
interface fill_chan_if
   import cache_pkg::*;
   ();

   logic                         req;        // Held until the last word
   logic [ADDR_W-WORD_OFF_W-1:0] addr;       // Line address
   logic                         word_valid;
   logic [WORD_OFF_W-1:0]        word_idx;
   logic [DATA_W-1:0]            rdata;

   modport cache
   (
      output req, output addr,
      input  word_valid, input word_idx, input rdata
   );

   modport backend
   (
      input  req, input addr,
      output word_valid, output word_idx, output rdata
   );

endinterface

`default_nettype wire

// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   ////////////////////
   // Cache geometry
   ////////////////////
   localparam int ADDR_W        = 14; // Word address of the data space
   localparam int DATA_W        = 32;
   localparam int NBYTES        = DATA_W / 8;
   localparam int LINE_OFF_W    = 4;  // 16 lines
   localparam int WORD_OFF_W    = 2;  // 4 words per line
   localparam int TAG_W         = ADDR_W - LINE_OFF_W - WORD_OFF_W;
   localparam int WTBUF_DEPTH_W = 2;  // 4 pending writes
   localparam int CTRL_ADDR_W   = 3;
   localparam int CNT_W         = 32;

   // One pending memory write
   typedef struct packed
   {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [NBYTES-1:0] strb;
   } wt_entry_t;

   ////////////////////
   // Control space
   ////////////////////
   typedef enum logic [CTRL_ADDR_W-1:0]
   {
      CTRL_READ_HIT    = 3'd0,
      CTRL_READ_MISS   = 3'd1,
      CTRL_WRITE_HIT   = 3'd2,
      CTRL_WRITE_MISS  = 3'd3,
      CTRL_WTBUF_EMPTY = 3'd4,
      CTRL_WTBUF_FULL  = 3'd5,
      CTRL_INVALIDATE  = 3'd6, // Write only
      CTRL_CLEAR       = 3'd7  // Write only, zeroes the counters
   } ctrl_reg_e;

endpackage

`default_nettype wire
